// ==== source/cart_config.svh ====
// Build-time constants of the cartridge memory subsystem.
// Include in every module that sizes the store or decodes the header.

`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

// word address width of the store, the top bit selects the RAM half
`define CART_STORE_AW 21

// data width of one store word, two byte lanes
`define CART_STORE_DW 16

// header word addresses in the download stream
// type byte $147 sits in the odd lane of word 'ha3
`define CART_HDR_TYPE_WADDR 24'ha3
// ROM size $148 in the even lane, RAM size $149 in the odd lane
`define CART_HDR_SIZE_WADDR 24'ha4

// ROM bank register value after reset
`define CART_RESET_ROM_BANK 5'd1

`endif

// ==== source/cart_pkg.sv ====
// Shared types of the cartridge memory subsystem.
// Holds the two views of the 16-bit cartridge address and the
// memory-map enums used by the mapper and the header capture.

`default_nettype none

package cart_pkg;

   // ----------------------------------------------------------------------
   // cartridge memory map
   // ----------------------------------------------------------------------

   // 8K regions selected by cart_addr[15:13]
   typedef enum logic [2:0] {
      reg_ram_enable = 3'b000,
      reg_rom_bank   = 3'b001,
      reg_ram_bank   = 3'b010,
      reg_mode       = 3'b011,
      ext_ram        = 3'b101
   } cart_region_e;

   // mapper family, decoded from header byte $147
   typedef enum logic {
      mbc_none = 1'b0,
      mbc_one  = 1'b1
   } mbc_kind_e;

   // one cartridge address seen two ways
   typedef union packed {
      // 16K areas, area 0 is the fixed bank, area 1 the switchable one
      struct packed {
         logic [1:0]  area;
         logic [13:0] offset;
      } rom_view;
      // 8K regions, the register windows and the external RAM window
      struct packed {
         cart_region_e region;
         logic [12:0]  offset;
      } ram_view;
   } cart_addr_u;

endpackage

`default_nettype wire

// ==== source/header_capture.sv ====
// Watches the download port and keeps the cartridge header bytes.
// Turns the MBC type into a mapper kind and the size bytes into the
// bank masks that give mirroring on small cartridges.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module header_capture import cart_pkg::*; (
   input  wire logic        clk64,
   input  wire logic        reset,
   input  wire logic        dio_download,
   input  wire logic        dio_write,
   input  wire logic [23:0] dio_addr,
   input  wire logic [15:0] dio_data,
   output mbc_kind_e        mbc_kind,
   output logic      [6:0]  rom_mask,
   output logic      [1:0]  ram_mask
);

   logic [7:0] mbc_type_q;
   logic [7:0] rom_size_q;
   logic [7:0] ram_size_q;

   // image is stored word-wide, so header byte addresses are halved
   always_ff @(posedge clk64) begin
      if (reset) begin
         mbc_type_q <= 8'h00;
         rom_size_q <= 8'h00;
         ram_size_q <= 8'h00;
      end else if (dio_download && dio_write) begin
         if (dio_addr == `CART_HDR_TYPE_WADDR)
            mbc_type_q <= dio_data[7:0];
         if (dio_addr == `CART_HDR_SIZE_WADDR)
            {rom_size_q, ram_size_q} <= dio_data;
      end
   end

   // types 1..3 are MBC1, MBC1+RAM and MBC1+RAM+battery
   assign mbc_kind = (mbc_type_q >= 8'd1 && mbc_type_q <= 8'd3) ? mbc_one : mbc_none;

   // size n means 2^(n+1) banks of 16K
   always_comb begin
      if (rom_size_q == 8'd0)
         rom_mask = 7'h03;
      else if (rom_size_q >= 8'd6)
         rom_mask = 7'h7f;
      else
         rom_mask = 7'h7f >> (3'd6 - rom_size_q[2:0]);
   end

   // only the 32K size has four banks, smaller RAMs never bank
   assign ram_mask = (ram_size_q >= 8'd3) ? 2'b11 : 2'b00;

endmodule

`default_nettype wire

// ==== source/mbc1_mapper.sv ====
// MBC1 bank mapper between the console's cartridge bus and the arbiter.
// Register writes and blocked RAM writes finish locally, reads and
// enabled RAM writes become one request towards the shared store.
// cart_done ends every accepted access.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module mbc1_mapper import cart_pkg::*; (
   input  wire logic                      clk64,
   input  wire logic                      reset,
   input  wire logic                      dio_download,
   input  wire cart_addr_u                cart_addr,
   input  wire logic                      cart_rd,
   input  wire logic                      cart_wr,
   input  wire logic [7:0]                cart_di,
   input  wire mbc_kind_e                 mbc_kind,
   input  wire logic [6:0]                rom_mask,
   input  wire logic [1:0]                ram_mask,
   input  wire logic                      rsp_cart_valid,
   input  wire logic [15:0]               rsp_data,
   output logic      [7:0]                cart_do,
   output logic                           cart_done,
   output logic                           cart_req_rd,
   output logic                           cart_req_wr,
   output logic      [`CART_STORE_AW-1:0] cart_req_addr,
   output logic      [1:0]                cart_req_be,
   output logic      [15:0]               cart_req_data
);

   localparam logic [`CART_STORE_AW-1:0] RAM_SEL = `CART_STORE_AW'(1) << (`CART_STORE_AW - 1);

   logic [4:0] rom_bank_q;
   logic [1:0] ram_bank_q;
   logic       ram_en_q;
   logic       mode_q;
   logic       busy_q;
   logic       odd_q;
   logic       accept_rd;
   logic       accept_wr;
   logic       is_ram;
   logic       is_reg;
   logic       reg_wr;
   logic [6:0] rom_bank;
   logic [1:0] ram_bank;
   logic [6:0] bank;

   // the bus is owned by the download while an image loads
   assign accept_rd = cart_rd && !dio_download;
   assign accept_wr = cart_wr && !dio_download;

   assign is_ram = cart_addr.ram_view.region == ext_ram;
   // everything below 8000 is a register window on writes
   assign is_reg = !cart_addr.rom_view.area[1];
   assign reg_wr = accept_wr && is_reg && mbc_kind == mbc_one;

   // ----------------------------------------------------------------------
   // control registers
   // ----------------------------------------------------------------------

   always_ff @(posedge clk64) begin
      if (reset) begin
         rom_bank_q <= `CART_RESET_ROM_BANK;
         ram_bank_q <= 2'd0;
         ram_en_q   <= 1'b0;
         mode_q     <= 1'b0;
      end else if (reg_wr) begin
         case (cart_addr.ram_view.region)
            reg_ram_enable: ram_en_q <= cart_di[3:0] == 4'ha;
            // bank 0 cannot be selected into the switchable window
            reg_rom_bank:   rom_bank_q <= (cart_di[4:0] == 5'd0) ? 5'd1 : cart_di[4:0];
            reg_ram_bank:   ram_bank_q <= cart_di[1:0];
            reg_mode:       mode_q <= cart_di[0];
            default:        ;
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // address translation
   // ----------------------------------------------------------------------

   // mode 0 lends the RAM bank bits to the ROM bank, mode 1 to the RAM
   assign rom_bank = {mode_q ? 2'b00 : ram_bank_q, rom_bank_q} & rom_mask;
   assign ram_bank = (mode_q ? ram_bank_q : 2'b00) & ram_mask;

   always_comb begin
      if (mbc_kind == mbc_none)
         bank = {6'd0, cart_addr.rom_view.area[0]};
      else if (cart_addr.rom_view.area == 2'b01)
         bank = rom_bank;
      else
         bank = 7'd0;
   end

   always_comb begin
      if (is_ram)
         cart_req_addr = RAM_SEL | `CART_STORE_AW'({ram_bank, cart_addr.ram_view.offset[12:1]});
      else
         cart_req_addr = `CART_STORE_AW'({bank, cart_addr.rom_view.offset[13:1]});
   end

   // even byte lives in the high lane
   assign cart_req_be   = cart_addr.rom_view.offset[0] ? 2'b01 : 2'b10;
   assign cart_req_data = {cart_di, cart_di};
   assign cart_req_rd   = accept_rd;
   assign cart_req_wr   = accept_wr && is_ram && ram_en_q;

   // ----------------------------------------------------------------------
   // completion
   // ----------------------------------------------------------------------

   always_ff @(posedge clk64) begin
      if (reset) begin
         cart_done <= 1'b0;
         busy_q    <= 1'b0;
      end else begin
         // locally finished writes end one cycle after the strobe
         cart_done <= (accept_wr && !cart_req_wr) || rsp_cart_valid;
         busy_q    <= (busy_q && !cart_done) || accept_rd || accept_wr;
      end
   end

   // lane of the outstanding access, picked when the word returns
   always_ff @(posedge clk64) begin
      if (accept_rd || accept_wr)
         odd_q <= cart_addr.rom_view.offset[0];
      if (rsp_cart_valid)
         cart_do <= odd_q ? rsp_data[7:0] : rsp_data[15:8];
   end

   a_done_has_access: assert property (@(posedge clk64) disable iff (reset)
      cart_done |-> busy_q);

   a_one_outstanding: assert property (@(posedge clk64) disable iff (reset)
      (cart_rd || cart_wr) |-> !busy_q);

endmodule

`default_nettype wire

// ==== source/mem_arbiter.sv ====
// Shares the single store port among download, cartridge and save.
// Each peer owns a one-entry pending slot, a request is granted in
// its own cycle when free and otherwise waits in the slot.
// Priority is download, cartridge, save.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module mem_arbiter (
   input  wire logic                        clk64,
   input  wire logic                        reset,
   input  wire logic                        dio_write,
   input  wire logic [23:0]                 dio_addr,
   input  wire logic [15:0]                 dio_data,
   input  wire logic                        cart_req_rd,
   input  wire logic                        cart_req_wr,
   input  wire logic [`CART_STORE_AW-1:0]   cart_req_addr,
   input  wire logic [1:0]                  cart_req_be,
   input  wire logic [15:0]                 cart_req_data,
   input  wire logic                        sav_rd,
   input  wire logic [12:0]                 sav_addr,
   output logic                             rsp_cart_valid,
   output logic                             sav_valid,
   output logic      [`CART_STORE_DW-1:0]   rsp_data,
   output logic      [`CART_STORE_DW-1:0]   sav_data,
   output logic                             mem_en,
   output logic                             mem_we,
   output logic      [`CART_STORE_AW-1:0]   mem_addr,
   output logic      [`CART_STORE_DW/8-1:0] mem_be,
   output logic      [`CART_STORE_DW-1:0]   mem_wdata,
   input  wire logic [`CART_STORE_DW-1:0]   mem_rdata
);

   localparam int AW = `CART_STORE_AW;
   localparam int DW = `CART_STORE_DW;
   localparam int BW = DW / 8;
   // request word is {we, be, addr, data}
   localparam int RW = 1 + BW + AW + DW;
   localparam logic [AW-1:0] RAM_SEL = AW'(1) << (AW - 1);

   logic [2:0]    strobe;
   logic [2:0]    want;
   logic [2:0]    gnt;
   logic [2:0]    pend_q;
   logic [RW-1:0] req_in [3];
   logic [RW-1:0] slot_q [3];
   logic [RW-1:0] cur    [3];
   logic [RW-1:0] sel;
   logic          cart_tag_q;
   logic          sav_tag_q;

   // peer 0 download, peer 1 cartridge, peer 2 save
   assign strobe    = {sav_rd, cart_req_rd || cart_req_wr, dio_write};
   assign req_in[0] = {1'b1, {BW{1'b1}}, dio_addr[AW-1:0], dio_data};
   assign req_in[1] = {cart_req_wr, cart_req_be, cart_req_addr, cart_req_data};
   // save reads always hit the RAM half
   assign req_in[2] = {1'b0, {BW{1'b1}}, RAM_SEL | AW'(sav_addr), {DW{1'b0}}};

   // a waiting slot stands in for its peer, a fresh strobe bypasses it
   always_comb begin
      for (int i = 0; i < 3; i++) begin
         want[i] = pend_q[i] || strobe[i];
         cur[i]  = pend_q[i] ? slot_q[i] : req_in[i];
      end
   end

   // fixed priority
   assign gnt[0] = want[0];
   assign gnt[1] = want[1] && !want[0];
   assign gnt[2] = want[2] && !want[1] && !want[0];

   always_comb begin
      sel = '0;
      for (int i = 0; i < 3; i++)
         if (gnt[i])
            sel = cur[i];
   end

   assign mem_en = |gnt;
   assign {mem_we, mem_be, mem_addr, mem_wdata} = sel;

   // ----------------------------------------------------------------------
   // pending slots
   // ----------------------------------------------------------------------

   always_ff @(posedge clk64) begin
      if (reset)
         pend_q <= 3'b000;
      else
         pend_q <= want & ~gnt;
   end

   always_ff @(posedge clk64) begin
      for (int i = 0; i < 3; i++)
         if (strobe[i] && !pend_q[i])
            slot_q[i] <= req_in[i];
   end

   // ----------------------------------------------------------------------
   // response routing
   // ----------------------------------------------------------------------

   // cartridge writes are tagged too, the mapper needs their completion
   always_ff @(posedge clk64) begin
      if (reset) begin
         cart_tag_q <= 1'b0;
         sav_tag_q  <= 1'b0;
         sav_valid  <= 1'b0;
      end else begin
         cart_tag_q <= gnt[1];
         sav_tag_q  <= gnt[2];
         sav_valid  <= sav_tag_q;
      end
   end

   // save data is held until the host takes the next one
   always_ff @(posedge clk64) begin
      if (sav_tag_q)
         sav_data <= mem_rdata;
   end

   assign rsp_cart_valid = cart_tag_q;
   assign rsp_data       = mem_rdata;

   // one cartridge request word carries either a read or a write
   a_one_cart_kind: assert property (@(posedge clk64) disable iff (reset)
      !(cart_req_rd && cart_req_wr));

   // peers keep at most one request in flight
   a_no_overwrite: assert property (@(posedge clk64) disable iff (reset)
      (strobe & pend_q) == 3'b000);

endmodule

`default_nettype wire

// ==== source/cart_store.sv ====
// On-chip word store holding the ROM image and the cartridge RAM.
// One port, byte lane write enables, read data registered one cycle
// after the enable.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module cart_store (
   input  wire logic                        clk64,
   input  wire logic                        mem_en,
   input  wire logic                        mem_we,
   input  wire logic [`CART_STORE_AW-1:0]   mem_addr,
   input  wire logic [`CART_STORE_DW/8-1:0] mem_be,
   input  wire logic [`CART_STORE_DW-1:0]   mem_wdata,
   output logic      [`CART_STORE_DW-1:0]   mem_rdata
);

   logic [`CART_STORE_DW-1:0] mem [2**`CART_STORE_AW];

   // read returns the old word on a write cycle
   always_ff @(posedge clk64) begin
      if (mem_en) begin
         if (mem_we) begin
            for (int b = 0; b < `CART_STORE_DW / 8; b++)
               if (mem_be[b])
                  mem[mem_addr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
         end
         mem_rdata <= mem[mem_addr];
      end
   end

endmodule

`default_nettype wire

// ==== source/cart_subsystem.sv ====
// Top of the cartridge memory subsystem.
// Connects the header capture, the MBC1 mapper, the store arbiter
// and the word store behind the download, cartridge and save ports.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module cart_subsystem import cart_pkg::*; (
   input  wire logic        clk64,
   input  wire logic        reset,
   // host download
   input  wire logic        dio_download,
   input  wire logic        dio_write,
   input  wire logic [23:0] dio_addr,
   input  wire logic [15:0] dio_data,
   // cartridge bus
   input  wire logic [15:0] cart_addr,
   input  wire logic        cart_rd,
   input  wire logic        cart_wr,
   input  wire logic [7:0]  cart_di,
   output logic      [7:0]  cart_do,
   output logic             cart_done,
   // host save readback
   input  wire logic        sav_rd,
   input  wire logic [12:0] sav_addr,
   output logic      [15:0] sav_data,
   output logic             sav_valid
);

   mbc_kind_e                   mbc_kind;
   logic [6:0]                  rom_mask;
   logic [1:0]                  ram_mask;
   logic                        cart_req_rd;
   logic                        cart_req_wr;
   logic [`CART_STORE_AW-1:0]   cart_req_addr;
   logic [1:0]                  cart_req_be;
   logic [15:0]                 cart_req_data;
   logic                        rsp_cart_valid;
   logic [`CART_STORE_DW-1:0]   rsp_data;
   logic                        mem_en;
   logic                        mem_we;
   logic [`CART_STORE_AW-1:0]   mem_addr;
   logic [`CART_STORE_DW/8-1:0] mem_be;
   logic [`CART_STORE_DW-1:0]   mem_wdata;
   logic [`CART_STORE_DW-1:0]   mem_rdata;

   header_capture u_hdr (
      .clk64 (clk64), .reset (reset),
      .dio_download (dio_download), .dio_write (dio_write),
      .dio_addr (dio_addr), .dio_data (dio_data),
      .mbc_kind (mbc_kind), .rom_mask (rom_mask), .ram_mask (ram_mask)
   );

   mbc1_mapper u_mbc (
      .clk64 (clk64), .reset (reset), .dio_download (dio_download),
      .cart_addr (cart_addr), .cart_rd (cart_rd), .cart_wr (cart_wr),
      .cart_di (cart_di), .mbc_kind (mbc_kind),
      .rom_mask (rom_mask), .ram_mask (ram_mask),
      .rsp_cart_valid (rsp_cart_valid), .rsp_data (rsp_data),
      .cart_do (cart_do), .cart_done (cart_done),
      .cart_req_rd (cart_req_rd), .cart_req_wr (cart_req_wr),
      .cart_req_addr (cart_req_addr), .cart_req_be (cart_req_be),
      .cart_req_data (cart_req_data)
   );

   mem_arbiter u_arb (
      .clk64 (clk64), .reset (reset),
      .dio_write (dio_write), .dio_addr (dio_addr), .dio_data (dio_data),
      .cart_req_rd (cart_req_rd), .cart_req_wr (cart_req_wr),
      .cart_req_addr (cart_req_addr), .cart_req_be (cart_req_be),
      .cart_req_data (cart_req_data),
      .sav_rd (sav_rd), .sav_addr (sav_addr),
      .rsp_cart_valid (rsp_cart_valid), .sav_valid (sav_valid),
      .rsp_data (rsp_data), .sav_data (sav_data),
      .mem_en (mem_en), .mem_we (mem_we), .mem_addr (mem_addr),
      .mem_be (mem_be), .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
   );

   cart_store u_store (
      .clk64 (clk64), .mem_en (mem_en), .mem_we (mem_we),
      .mem_addr (mem_addr), .mem_be (mem_be),
      .mem_wdata (mem_wdata), .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== tests/cart_tb.sv ====
// Testbench for the cartridge memory subsystem.
// Downloads random images, runs MBC1 banking and RAM traffic with save
// readback in parallel, and checks every byte and word against a model.
// Stimulus comes from an LFSR with a fixed seed.

`timescale 1ns/10ps
`default_nettype none

`include "cart_config.svh"

module cart_tb;

   localparam int N_B1 = 256;
   localparam int N_B2 = 256;
   localparam int N_B3 = 256;
   localparam int N_B4 = 256;
   localparam int N_B5 = 256;
   // first image, RAM preload, second image, header reload, idle edges
   localparam int DL_CYCLES = 32768 + 16384 + 16384 + 2 + 64;
   localparam int ACCESSES = N_B1 + 21 + 3 * N_B2 + 132 + 3 * N_B3 + 3 * N_B4 + 4 * N_B5;
   localparam int LIMIT = 2 * (DL_CYCLES + 64 * ACCESSES);
   localparam logic [23:0] RAM_BASE = 24'h1 << (`CART_STORE_AW - 1);

   logic        clk64;
   logic        reset;
   logic        dio_download;
   logic        dio_write;
   logic [23:0] dio_addr;
   logic [15:0] dio_data;
   logic [15:0] cart_addr;
   logic        cart_rd;
   logic        cart_wr;
   logic [7:0]  cart_di;
   logic [7:0]  cart_do;
   logic        cart_done;
   logic        sav_rd;
   logic [12:0] sav_addr;
   logic [15:0] sav_data;
   logic        sav_valid;

   // reference model
   logic [7:0]  rom_img [65536];
   logic [7:0]  ram_img [32768];
   logic        m_mbc1;
   logic [6:0]  m_rom_mask;
   logic [1:0]  m_ram_mask;
   logic [4:0]  m_rom_bank;
   logic [1:0]  m_ram_bank;
   logic        m_ram_en;
   logic        m_mode;

   logic [31:0] lfsr_q;
   int          err_count = 0;
   int          cycles = 0;
   logic [12:0] sav_plan_addr [N_B4];
   int          sav_plan_gap  [N_B4];

   cart_subsystem dut_i (
      .clk64        (clk64),
      .reset        (reset),
      .dio_download (dio_download),
      .dio_write    (dio_write),
      .dio_addr     (dio_addr),
      .dio_data     (dio_data),
      .cart_addr    (cart_addr),
      .cart_rd      (cart_rd),
      .cart_wr      (cart_wr),
      .cart_di      (cart_di),
      .cart_do      (cart_do),
      .cart_done    (cart_done),
      .sav_rd       (sav_rd),
      .sav_addr     (sav_addr),
      .sav_data     (sav_data),
      .sav_valid    (sav_valid)
   );

   initial begin
      clk64 = 1'b0;
      forever #50 clk64 = ~clk64;
   end

   // watchdog over the whole run
   always @(posedge clk64) begin
      cycles <= cycles + 1;
      if (cycles > LIMIT)
         report_failure($sformatf("run did not finish within %0d cycles", LIMIT));
   end

   // ---------------------------------------------------------------------
   // random numbers
   // ---------------------------------------------------------------------

   // taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one LFSR step per bit
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   // ---------------------------------------------------------------------
   // reporting and checks
   // ---------------------------------------------------------------------

   task automatic report_failure(input string msg);
      err_count++;
      $display("%s", msg);
      $display("ERRORS FOUND");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         report_failure($sformatf("CHECK FAILED %s expected %02h actual %02h", name, exp, act));
   endtask

   task automatic check_word(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
      if (act !== exp)
         report_failure($sformatf("CHECK FAILED %s expected %04h actual %04h", name, exp, act));
   endtask

   // ---------------------------------------------------------------------
   // model of the header and the MBC1 registers
   // ---------------------------------------------------------------------

   task automatic header_model();
      logic [7:0] rom_size;
      rom_size = rom_img[16'h148];
      m_mbc1 = rom_img[16'h147] >= 8'd1 && rom_img[16'h147] <= 8'd3;
      // n+1 low ones, two at least, seven at most
      if (rom_size >= 8'd6)
         m_rom_mask = 7'h7f;
      else if (rom_size == 8'd0)
         m_rom_mask = 7'h03;
      else
         m_rom_mask = 7'((1 << (rom_size + 1)) - 1);
      m_ram_mask = (rom_img[16'h149] >= 8'd3) ? 2'b11 : 2'b00;
   endtask

   task automatic model_reset();
      m_rom_bank = 5'd1;
      m_ram_bank = 2'd0;
      m_ram_en   = 1'b0;
      m_mode     = 1'b0;
      m_mbc1     = 1'b0;
      m_rom_mask = 7'h03;
      m_ram_mask = 2'b00;
   endtask

   // byte index into ram_img for an A000..BFFF address
   function automatic int ram_index(input logic [15:0] a);
      logic [1:0] rb;
      rb = (m_mode ? m_ram_bank : 2'b00) & m_ram_mask;
      return int'({rb, a[12:0]});
   endfunction

   function automatic logic [7:0] expect_byte(input logic [15:0] a);
      logic [6:0] bank;
      bank = {(m_mode ? 2'b00 : m_ram_bank), m_rom_bank} & m_rom_mask;
      if (a[15:13] == 3'b101)
         return ram_img[ram_index(a)];
      else if (!m_mbc1)
         return rom_img[int'(a[14:0])];
      else if (a[15:14] == 2'b01)
         return rom_img[int'({bank, a[13:0]})];
      else
         return rom_img[int'(a[13:0])];
   endfunction

   task automatic model_write(input logic [15:0] a, input logic [7:0] d);
      if (!a[15]) begin
         // register windows, ignored without a mapper
         if (m_mbc1) begin
            case (a[14:13])
               2'd0: m_ram_en = d[3:0] == 4'ha;
               2'd1: m_rom_bank = (d[4:0] == 5'd0) ? 5'd1 : d[4:0];
               2'd2: m_ram_bank = d[1:0];
               default: m_mode = d[0];
            endcase
         end
      end else if (a[15:13] == 3'b101 && m_ram_en) begin
         ram_img[ram_index(a)] = d;
      end
   endtask

   // ---------------------------------------------------------------------
   // bus tasks
   // ---------------------------------------------------------------------

   task automatic cart_access(input logic wr, input logic [15:0] a, input logic [7:0] d,
                              output logic [7:0] q);
      int n;
      n = 0;
      @(posedge clk64);
      cart_addr <= a;
      cart_di   <= d;
      cart_rd   <= !wr;
      cart_wr   <= wr;
      @(posedge clk64);
      cart_rd <= 1'b0;
      cart_wr <= 1'b0;
      while (!cart_done && n < 50) begin
         @(posedge clk64);
         n++;
      end
      if (!cart_done)
         report_failure($sformatf("no cart_done within 50 cycles of the access at %04h", a));
      q = cart_do;
   endtask

   task automatic do_write(input logic [15:0] a, input logic [7:0] d);
      logic [7:0] q;
      model_write(a, d);
      cart_access(1'b1, a, d, q);
   endtask

   task automatic do_read(input string name, input logic [15:0] a);
      logic [7:0] exp;
      logic [7:0] q;
      exp = expect_byte(a);
      cart_access(1'b0, a, 8'h00, q);
      check_byte($sformatf("%s @%04h", name, a), exp, q);
   endtask

   task automatic save_read(input logic [12:0] a);
      int n;
      n = 0;
      @(posedge clk64);
      sav_addr <= a;
      sav_rd   <= 1'b1;
      @(posedge clk64);
      sav_rd <= 1'b0;
      while (!sav_valid && n < 50) begin
         @(posedge clk64);
         n++;
      end
      if (!sav_valid)
         report_failure($sformatf("no sav_valid within 50 cycles of the read at %04h", a));
      check_word($sformatf("save read @%04h", a),
                 {ram_img[2 * int'(a)], ram_img[2 * int'(a) + 1]}, sav_data);
   endtask

   task automatic download_word(input logic [23:0] a, input logic [15:0] d);
      @(posedge clk64);
      dio_download <= 1'b1;
      dio_write    <= 1'b1;
      dio_addr     <= a;
      dio_data     <= d;
   endtask

   task automatic download_end();
      @(posedge clk64);
      dio_write    <= 1'b0;
      dio_download <= 1'b0;
   endtask

   // even byte in the high lane
   task automatic download_rom(input int words);
      for (int w = 0; w < words; w++)
         download_word(24'(w), {rom_img[2 * w], rom_img[2 * w + 1]});
   endtask

   task automatic pulse_reset();
      @(posedge clk64);
      reset <= 1'b1;
      repeat (10) @(posedge clk64);
      reset <= 1'b0;
      model_reset();
   endtask

   // ---------------------------------------------------------------------
   // test sequence
   // ---------------------------------------------------------------------

   initial begin
      logic [15:0] a;
      logic [15:0] w;
      logic [1:0]  k;
      reset        = 1'b1;
      dio_download = 1'b0;
      dio_write    = 1'b0;
      dio_addr     = '0;
      dio_data     = '0;
      cart_addr    = '0;
      cart_rd      = 1'b0;
      cart_wr      = 1'b0;
      cart_di      = '0;
      sav_rd       = 1'b0;
      sav_addr     = '0;
      lfsr_q       = 32'ha189_d1c5;
      model_reset();

      // 64K image, MBC1, ROM size 1, 32K RAM
      for (int i = 0; i < 65536; i++)
         rom_img[i] = 8'(take_bits(8));
      rom_img[16'h147] = 8'h01;
      rom_img[16'h148] = 8'h01;
      rom_img[16'h149] = 8'h03;
      repeat (10) @(posedge clk64);
      reset <= 1'b0;

      // behavior 1: image download, RAM preload, fixed bank reads
      download_rom(32768);
      for (int i = 0; i < 16384; i++) begin
         w = 16'(i * 32'h9e37 + 32'h1234);
         ram_img[2 * i]     = w[15:8];
         ram_img[2 * i + 1] = w[7:0];
         download_word(RAM_BASE | 24'(i), w);
      end
      download_end();
      header_model();
      for (int i = 0; i < N_B1; i++)
         do_read("bank 0 read", {2'b00, 14'(take_bits(14))});

      // disturb every register, then reset and reload the header
      do_write(16'h2000, 8'h03);
      do_write(16'h4000, 8'h02);
      do_write(16'h6000, 8'h01);
      do_write(16'h0000, 8'h0a);
      pulse_reset();
      download_word(24'ha3, {rom_img[16'h146], rom_img[16'h147]});
      download_word(24'ha4, {rom_img[16'h148], rom_img[16'h149]});
      download_end();
      header_model();

      // behavior 2 and 6: reset bank first, then random banking
      for (int i = 0; i < 8; i++)
         do_read("bank after reset", {2'b01, 14'(take_bits(14))});
      // RAM bank register back at 0, seen through the RAM window in mode 1
      do_write(16'h6000, 8'h01);
      for (int i = 0; i < 8; i++)
         do_read("RAM bank after reset", {3'b101, 13'(take_bits(13))});
      for (int i = 0; i < N_B2; i++) begin
         k = 2'(take_bits(2));
         a = 16'(take_bits(13));
         case (k)
            2'd0: do_write(16'h2000 | a, 8'(take_bits(8)));
            2'd1: do_write(16'h4000 | a, 8'(take_bits(8)));
            2'd2: do_write(16'h6000 | a, 8'(take_bits(1)));
            // bank 0 is remapped to 1
            default: do_write(16'h2000 | a, {3'(take_bits(3)), 5'd0});
         endcase
         do_read("switchable bank read", {2'b01, 14'(take_bits(14))});
         do_read("switchable bank read", {2'b01, 14'(take_bits(14))});
      end

      // behavior 3: RAM stays disabled until a write of hex a
      for (int i = 0; i < 16; i++) begin
         a = {3'b101, 13'(take_bits(13))};
         do_write(a, 8'(take_bits(8)));
         do_read("disabled RAM read", a);
      end
      do_write(16'(take_bits(13)), {4'(take_bits(4)), 4'ha});
      do_write(16'h6000, 8'h01);
      for (int i = 0; i < N_B3; i++) begin
         do_write(16'h4000 | 16'(take_bits(13)), 8'(take_bits(8)));
         a = {3'b101, 13'(take_bits(13))};
         do_write(a, 8'(take_bits(8)));
         do_read("banked RAM read", a);
      end
      // mode 0 pins the RAM to bank 0
      do_write(16'h6000, 8'h00);
      for (int i = 0; i < 32; i++) begin
         do_write(16'h4000 | 16'(take_bits(13)), 8'(take_bits(8)));
         a = {3'b101, 13'(take_bits(13))};
         do_write(a, 8'(take_bits(8)));
         do_read("mode 0 RAM read", a);
      end

      // behavior 4: save reads of banks 0 and 1 while the cartridge
      // works in banks 2 and 3
      do_write(16'h6000, 8'h01);
      for (int i = 0; i < N_B4; i++) begin
         sav_plan_addr[i] = 13'(take_bits(13));
         sav_plan_gap[i]  = int'(take_bits(2));
      end
      fork
         begin
            for (int i = 0; i < N_B4; i++) begin
               do_write(16'h4000 | 16'(take_bits(13)), 8'(take_bits(8)) | 8'h02);
               k = 2'(take_bits(2));
               a = {3'b101, 13'(take_bits(13))};
               if (k == 2'd0)
                  do_read("rom read beside save", {1'b0, 15'(take_bits(15))});
               else if (k == 2'd1)
                  do_write(a, 8'(take_bits(8)));
               else
                  do_read("RAM read beside save", a);
            end
         end
         begin
            for (int i = 0; i < N_B4; i++) begin
               repeat (sav_plan_gap[i]) @(posedge clk64);
               save_read(sav_plan_addr[i]);
            end
         end
      join

      // behavior 5: 32K image without a mapper
      for (int i = 0; i < 32768; i++)
         rom_img[i] = 8'(take_bits(8));
      rom_img[16'h147] = 8'h00;
      rom_img[16'h148] = 8'h00;
      rom_img[16'h149] = 8'h00;
      download_rom(16384);
      download_end();
      header_model();
      for (int i = 0; i < N_B5; i++) begin
         do_write({1'b0, 15'(take_bits(15))}, 8'(take_bits(8)));
         do_read("linear upper half read", {2'b01, 14'(take_bits(14))});
         // RAM enable is left alone by the ignored register writes
         a = {3'b101, 13'(take_bits(13))};
         do_write(a, 8'(take_bits(8)));
         do_read("RAM read without mapper", a);
      end

      @(posedge clk64);
      if (err_count == 0) begin
         $display("NO ERRORS");
         $finish;
      end else begin
         report_failure("checks failed during the run");
      end
   end

endmodule

`default_nettype wire

// ==== cart_subsystem.f ====
+incdir+source
source/cart_pkg.sv
source/header_capture.sv
source/mbc1_mapper.sv
source/mem_arbiter.sv
source/cart_store.sv
source/cart_subsystem.sv
tests/cart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and decide pass or fail
# from the simulation log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cart_tb \
   -f cart_subsystem.f -o cart_sim > build.log 2>&1 \
   || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cart_sim > sim.log 2>&1
cat sim.log

grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
